// File: sim.f
+incdir+.
qracc_cfg_pkg.sv
qracc_data_pkg.sv
qracc_csr.sv
qracc_act_buffer.sv
qracc_controller.sv
qracc_mac.sv
qracc_top.sv
tb_qracc.sv

// File: Bender.yml
package:
  name: qracc

sources:
  - qracc_cfg_pkg.sv
  - qracc_data_pkg.sv
  - qracc_csr.sv
  - qracc_act_buffer.sv
  - qracc_controller.sv
  - qracc_mac.sv
  - qracc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_qracc.sv

// File: tb_qracc_checks.svh
// Testbench checks on read values, APB protocol and reset state
// Included inside tb_qracc after the DUT instance
`ifndef TB_QRACC_CHECKS_SVH
`define TB_QRACC_CHECKS_SVH

int mismatch_count = 0;
int other_count    = 0;
int checked_count  = 0;

// Checked reads of CONFIG, STATUS and DATA
read_value: assert property (@(posedge clk) disable iff (!nrst)
    chk_en && psel && penable && !pwrite && pready |-> prdata == chk_exp)
    else begin
        mismatch_count++;
        $display("Mismatch prdata_o at addr %h: got %h, expected %h",
                 $sampled(paddr), $sampled(prdata), $sampled(chk_exp));
    end

// Pixel reads are zero-extended
data_zero_ext: assert property (@(posedge clk) disable iff (!nrst)
    psel && penable && !pwrite && pready && paddr == CSR_ADDR_DATA |-> prdata[31:8] == '0)
    else begin
        mismatch_count++;
        $display("Mismatch prdata_o[31:8] on a data read: got %h, expected %h",
                 $sampled(prdata[31:8]), 24'h0);
    end

no_slverr: assert property (@(posedge clk) disable iff (!nrst)
    psel && penable && pready |-> !pslverr)
    else begin
        other_count++;
        $display("APB slave answered with an error at addr %h", $sampled(paddr));
    end

ready_in_setup: assert property (@(posedge clk) disable iff (!nrst)
    psel && !penable |-> !pready)
    else begin
        other_count++;
        $display("pready was high during an APB setup phase");
    end

// Busy, valids and enables stay low while reset is held
reset_state: assert property (@(posedge clk)
    !nrst |-> !pready && !uut.busy && !uut.data_rd_valid && !uut.buf_req.en
              && !uut.tap.valid && !uut.wgt_wr.en && !uut.result_valid)
    else begin
        other_count++;
        $display("A status, valid or enable output was high during reset");
    end

`endif

// File: tb_qracc.sv
// Testbench for the convolution accelerator that drives the APB port of qracc_top
// Runs loads, convolutions, readback and an aborted compute against a software model
`timescale 1ns/100ps
`default_nettype none

module tb_qracc
    import qracc_cfg_pkg::*;
();

    localparam int MAX_DIM            = 16;
    localparam int BUF_DEPTH          = 512;
    localparam int SEED               = 20;
    // Five runs of four commands each where the abort run counts its clear
    localparam int NUM_COMMANDS       = 20;
    localparam int CYCLES_PER_COMMAND = 2000;

    logic        clk;
    logic        nrst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Expected read word held through the whole APB transfer
    logic        chk_en;
    logic [31:0] chk_exp;

    logic [7:0]        pix [MAX_DIM*MAX_DIM+4];
    logic signed [7:0] wgt [9];
    int unsigned       seed_init;

    qracc_top #(
        .MAX_DIM   (MAX_DIM),
        .BUF_DEPTH (BUF_DEPTH)
    ) uut (
        .clk       (clk),
        .nrst      (nrst),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

`include "tb_qracc_checks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // APB driver
    ////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready) begin
            @(posedge clk);
        end
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, input logic check,
                            input logic [31:0] expected, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        chk_en  <= check;
        chk_exp <= expected;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready) begin
            @(posedge clk);
        end
        data = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
        chk_en  <= 1'b0;
        if (check) begin
            checked_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Commands
    ////////////////////////////////////////////////////////////

    // Busy must already show on STATUS right after the trigger
    task automatic start_cmd(input qracc_trigger_t trig);
        logic [31:0] rd;
        apb_write(CSR_ADDR_MAIN, 32'(trig));
        apb_read(CSR_ADDR_STATUS, 1'b1, 32'd1, rd);
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        st = 32'd1;
        while (st[0]) begin
            apb_read(CSR_ADDR_STATUS, 1'b0, 32'd0, st);
        end
    endtask

    task automatic set_config(input int dim, input int fs, input int sh);
        qracc_config_t cfg;
        logic [31:0]   rd;
        cfg             = '0;
        cfg.fmap_dim    = 5'(dim);
        cfg.filter_size = 2'(fs);
        cfg.out_shift   = 5'(sh);
        apb_write(CSR_ADDR_CONFIG, cfg);
        apb_read(CSR_ADDR_CONFIG, 1'b1, cfg, rd);
    endtask

    task automatic load_acts(input int dim);
        logic [31:0] w;
        start_cmd(TRIG_LOAD_ACTS);
        for (int i = 0; i < dim * dim; i += 4) begin
            w = {pix[i+3], pix[i+2], pix[i+1], pix[i]};
            apb_write(CSR_ADDR_DATA, w);
        end
        wait_idle();
    endtask

    function automatic logic [31:0] weight_word(input int k);
        logic [31:0] w;
        w = '0;
        for (int l = 0; l < 4; l++) begin
            if (4 * k + l < 9) begin
                w[8*l +: 8] = wgt[4*k + l];
            end
        end
        return w;
    endfunction

    task automatic load_weights();
        start_cmd(TRIG_LOAD_WEIGHTS);
        for (int k = 0; k < 3; k++) begin
            apb_write(CSR_ADDR_DATA, weight_word(k));
        end
        wait_idle();
    endtask

    // Accumulate, arithmetic shift, ReLU, saturate to 255
    function automatic logic [7:0] ref_pixel(input int oy, input int ox, input int dim,
                                             input int fs, input int sh);
        int acc;
        acc = 0;
        for (int fy = 0; fy < fs; fy++) begin
            for (int fx = 0; fx < fs; fx++) begin
                acc += int'(pix[(oy + fy) * dim + ox + fx]) * int'(wgt[fy * fs + fx]);
            end
        end
        acc = acc >>> sh;
        if (acc < 0) begin
            return 8'd0;
        end else if (acc > 255) begin
            return 8'd255;
        end
        return acc[7:0];
    endfunction

    task automatic read_outputs(input int dim, input int fs, input int sh);
        int          od;
        logic [31:0] rd;
        od = dim - fs + 1;
        start_cmd(TRIG_READ_ACTS);
        for (int oy = 0; oy < od; oy++) begin
            for (int ox = 0; ox < od; ox++) begin
                apb_read(CSR_ADDR_DATA, 1'b1, {24'd0, ref_pixel(oy, ox, dim, fs, sh)}, rd);
            end
        end
        wait_idle();
    endtask

    task automatic run_layer(input int dim, input int fs, input int sh);
        set_config(dim, fs, sh);
        load_acts(dim);
        load_weights();
        start_cmd(TRIG_COMPUTE);
        wait_idle();
        read_outputs(dim, fs, sh);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus data
    ////////////////////////////////////////////////////////////

    function automatic void fill_random(input int dim);
        for (int i = 0; i < dim * dim; i++) begin
            pix[i] = 8'($urandom);
        end
        for (int k = 0; k < 9; k++) begin
            wgt[k] = 8'($urandom);
        end
    endfunction

    // Bright columns 0, 1 and 5 on a 6x6 map with positive left and negative right weights
    function automatic void fill_split_pattern();
        int v;
        for (int y = 0; y < 6; y++) begin
            for (int x = 0; x < 6; x++) begin
                if (x < 2 || x == 5) begin
                    pix[y * 6 + x] = 8'(240 + $urandom % 16);
                end else begin
                    pix[y * 6 + x] = 8'($urandom % 16);
                end
            end
        end
        for (int k = 0; k < 9; k++) begin
            case (k % 3)
                0:       v = 64 + int'($urandom % 64);
                1:       v = int'($urandom % 16) - 8;
                default: v = -64 - int'($urandom % 65);
            endcase
            wgt[k] = 8'(v);
        end
    endfunction

    task automatic report_and_finish();
        $display("Errors: %0d mismatches, %0d other failures, %0d reads checked",
                 mismatch_count, other_count, checked_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        logic [31:0] word;
        seed_init = $urandom(SEED);
        nrst    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        chk_en  = 1'b0;
        chk_exp = '0;
        repeat (16) @(posedge clk);
        nrst <= 1'b1;

        // Idle after reset and a config register that holds every bit
        apb_read(CSR_ADDR_STATUS, 1'b1, 32'd0, rd);
        word = $urandom;
        apb_write(CSR_ADDR_CONFIG, word);
        apb_read(CSR_ADDR_CONFIG, 1'b1, word, rd);

        fill_split_pattern();
        run_layer(6, 3, 4);
        fill_random(8);
        run_layer(8, 1, 2);
        fill_random(5);
        run_layer(5, 2, 3);

        // Abort a running compute and run a clean layer after it
        fill_random(6);
        set_config(6, 3, 4);
        load_acts(6);
        load_weights();
        start_cmd(TRIG_COMPUTE);
        apb_write(CSR_ADDR_MAIN, 32'h8);
        apb_read(CSR_ADDR_STATUS, 1'b1, 32'd0, rd);
        fill_random(6);
        run_layer(6, 3, 4);

        report_and_finish();
    end

    initial begin
        repeat (NUM_COMMANDS * CYCLES_PER_COMMAND) @(posedge clk);
        other_count++;
        $display("Watchdog timeout after %0d cycles, the test sequence did not finish",
                 NUM_COMMANDS * CYCLES_PER_COMMAND);
        report_and_finish();
    end

endmodule

`default_nettype wire

// File: qracc_top.sv
// Accelerator top level with an APB slave port
// Connects the register block, controller, activation buffer and MAC unit
`timescale 1ns/100ps
`default_nettype none

module qracc_top
    import qracc_cfg_pkg::*;
    import qracc_data_pkg::*;
#(
    parameter int MAX_DIM   = 16,
    parameter int BUF_DEPTH = 512
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  logic [3:0]  paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic        pready_o,
    output logic        pslverr_o
);

    qracc_config_t cfg;
    qracc_cmd_t    cmd;
    logic          busy;
    logic          data_wr_valid;
    qracc_word_u   data_wr;
    logic          data_wr_ready;
    logic          data_rd_req;
    logic          data_rd_valid;
    act_t          data_rd;
    act_buf_req_t  buf_req;
    act_t          buf_rdata;
    mac_tap_t      tap;
    wgt_wr_t       wgt_wr;
    logic          result_valid;
    act_t          result;

    qracc_csr u_csr (
        .clk             (clk),
        .nrst            (nrst),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .paddr_i         (paddr_i),
        .pwdata_i        (pwdata_i),
        .prdata_o        (prdata_o),
        .pready_o        (pready_o),
        .pslverr_o       (pslverr_o),
        .cfg_o           (cfg),
        .cmd_o           (cmd),
        .busy_i          (busy),
        .data_wr_valid_o (data_wr_valid),
        .data_wr_o       (data_wr),
        .data_wr_ready_i (data_wr_ready),
        .data_rd_req_o   (data_rd_req),
        .data_rd_valid_i (data_rd_valid),
        .data_rd_i       (data_rd)
    );

    qracc_controller #(
        .MAX_DIM   (MAX_DIM),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_ctrl (
        .clk             (clk),
        .nrst            (nrst),
        .cfg_i           (cfg),
        .cmd_i           (cmd),
        .busy_o          (busy),
        .data_wr_valid_i (data_wr_valid),
        .word_i          (data_wr),
        .data_wr_ready_o (data_wr_ready),
        .data_rd_req_i   (data_rd_req),
        .data_rd_valid_o (data_rd_valid),
        .data_rd_o       (data_rd),
        .buf_req_o       (buf_req),
        .buf_rdata_i     (buf_rdata),
        .tap_o           (tap),
        .wgt_wr_o        (wgt_wr),
        .result_valid_i  (result_valid),
        .result_i        (result)
    );

    qracc_act_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_buf (
        .clk     (clk),
        .nrst    (nrst),
        .req_i   (buf_req),
        .rdata_o (buf_rdata)
    );

    qracc_mac u_mac (
        .clk            (clk),
        .nrst           (nrst),
        .cfg_i          (cfg),
        .tap_i          (tap),
        .wgt_wr_i       (wgt_wr),
        .result_valid_o (result_valid),
        .result_o       (result)
    );

endmodule

`default_nettype wire

// File: qracc_mac.sv
// Weight store and multiply-accumulate for one output pixel at a time
// Shift, ReLU and saturation are applied on the last tap
`timescale 1ns/100ps
`default_nettype none

module qracc_mac
    import qracc_cfg_pkg::*;
    import qracc_data_pkg::*;
(
    input  logic          clk,
    input  logic          nrst,
    input  qracc_config_t cfg_i,
    input  mac_tap_t      tap_i,
    input  wgt_wr_t       wgt_wr_i,
    output logic          result_valid_o,
    output act_t          result_o
);

    localparam int NUM_WGT = 9;

    wgt_t               wgt_q [NUM_WGT];
    logic signed [16:0] prod;
    logic signed [31:0] acc_q;
    logic signed [31:0] acc_base;
    logic signed [31:0] acc_sum;
    logic signed [31:0] shifted;
    act_t               clamped;

    // Four weights per word with lanes beyond the last register dropped
    always_ff @(posedge clk) begin
        if (wgt_wr_i.en) begin
            for (int i = 0; i < 4; i++) begin
                if (int'(wgt_wr_i.base) + i < NUM_WGT) begin
                    wgt_q[int'(wgt_wr_i.base) + i] <= wgt_wr_i.word.wgts[i];
                end
            end
        end
    end

    // Unsigned pixel gets a zero on top before the signed multiply
    assign prod     = $signed({1'b0, tap_i.pixel}) * wgt_q[tap_i.tap];
    assign acc_base = tap_i.first ? '0 : acc_q;
    assign acc_sum  = acc_base + prod;
    assign shifted  = acc_sum >>> cfg_i.out_shift;

    always_comb begin
        if (shifted < 0) begin
            clamped = '0;
        end else if (shifted > 32'sd255) begin
            clamped = 8'd255;
        end else begin
            clamped = shifted[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (tap_i.valid) begin
            acc_q <= acc_sum;
        end
        if (tap_i.valid && tap_i.last) begin
            result_o <= clamped;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= tap_i.valid && tap_i.last;
        end
    end

    // Walk in the controller must stay inside the configured filter
    assert property (@(posedge clk) disable iff (!nrst)
        tap_i.valid |-> tap_i.tap < cfg_i.filter_size * cfg_i.filter_size);

endmodule

`default_nettype wire

// File: qracc_controller.sv
// Command sequencer between the APB block, the activation buffer and the MAC unit
// Runs activation and weight loads, the convolution walk and the output readback
`timescale 1ns/100ps
`default_nettype none

module qracc_controller
    import qracc_cfg_pkg::*;
    import qracc_data_pkg::*;
#(
    parameter int MAX_DIM   = 16,
    parameter int BUF_DEPTH = 512
) (
    input  logic          clk,
    input  logic          nrst,
    input  qracc_config_t cfg_i,
    input  qracc_cmd_t    cmd_i,
    output logic          busy_o,
    input  logic          data_wr_valid_i,
    input  qracc_word_u   word_i,
    output logic          data_wr_ready_o,
    input  logic          data_rd_req_i,
    output logic          data_rd_valid_o,
    output act_t          data_rd_o,
    output act_buf_req_t  buf_req_o,
    input  act_t          buf_rdata_i,
    output mac_tap_t      tap_o,
    output wgt_wr_t       wgt_wr_o,
    input  logic          result_valid_i,
    input  act_t          result_i
);

    localparam int AW = $clog2(BUF_DEPTH);
    localparam int DW = $clog2(MAX_DIM + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD_ACTS,
        S_LOAD_WEIGHTS,
        S_COMPUTE,
        S_READ_ACTS
    } state_t;

    state_t        state_q;
    state_t        state_d;

    // Map geometry
    logic [DW-1:0] dim;
    logic [DW-1:0] fs;
    logic [DW-1:0] out_dim;
    logic [AW-1:0] npix;
    logic [AW-1:0] nout;

    // Loads
    logic          wr_hs;
    logic          act_wr;
    logic [1:0]    lane_q;
    logic [AW-1:0] act_ptr_q;
    qracc_word_u   word_q;
    logic [1:0]    wcnt_q;

    // Window walk
    logic [DW-1:0] ox_q;
    logic [DW-1:0] oy_q;
    logic [DW-1:0] fx_q;
    logic [DW-1:0] fy_q;
    logic          fx_end;
    logic          fy_end;
    logic          ox_end;
    logic          oy_end;
    logic          walk_done_q;
    logic          walking;
    logic          rd_fire;
    logic [AW-1:0] rd_addr;
    logic [AW-1:0] out_ptr_q;
    logic [3:0]    tap_ctr_q;
    logic          tap_valid_q;
    logic [3:0]    tap_idx_q;
    logic          tap_first_q;
    logic          tap_last_q;

    // Readback
    logic [AW-1:0] rd_ptr_q;
    logic          rd_issue;
    logic          pend_q;
    logic          rvalid_q;
    act_t          data_rd_q;

    assign dim     = DW'(cfg_i.fmap_dim);
    assign fs      = DW'(cfg_i.filter_size);
    assign out_dim = dim - fs + 1'b1;
    assign npix    = AW'(dim) * AW'(dim);
    assign nout    = AW'(out_dim) * AW'(out_dim);

    assign busy_o = (state_q != S_IDLE);

    ////////////////////////////////////////////////////////////
    // Command FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                case (cmd_i.trigger)
                    TRIG_LOAD_ACTS:    state_d = S_LOAD_ACTS;
                    TRIG_LOAD_WEIGHTS: state_d = S_LOAD_WEIGHTS;
                    TRIG_COMPUTE:      state_d = S_COMPUTE;
                    TRIG_READ_ACTS:    state_d = S_READ_ACTS;
                    default:           state_d = S_IDLE;
                endcase
            end
            S_LOAD_ACTS: begin
                if (act_wr && act_ptr_q == npix - 1'b1) state_d = S_IDLE;
            end
            S_LOAD_WEIGHTS: begin
                if (wr_hs && wcnt_q == 2'd2) state_d = S_IDLE;
            end
            S_COMPUTE: begin
                // Done once the last output pixel is written back
                if (result_valid_i && out_ptr_q == nout - 1'b1) state_d = S_IDLE;
            end
            S_READ_ACTS: begin
                if (rvalid_q && rd_ptr_q == nout - 1'b1) state_d = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
        if (cmd_i.clear) begin
            state_d = S_IDLE;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Data words in, readback out
    ////////////////////////////////////////////////////////////

    // One word per four cycles while unpacking pixels and a weight word every cycle
    assign data_wr_ready_o = ((state_q == S_LOAD_ACTS) && (lane_q == 2'd0))
                           || (state_q == S_LOAD_WEIGHTS);
    assign wr_hs  = data_wr_valid_i && data_wr_ready_o;
    assign act_wr = (state_q == S_LOAD_ACTS) && ((lane_q == 2'd0) ? wr_hs : 1'b1);

    assign wgt_wr_o.en   = (state_q == S_LOAD_WEIGHTS) && wr_hs;
    assign wgt_wr_o.word = word_i;
    assign wgt_wr_o.base = {wcnt_q, 2'b00};

    assign rd_issue = (state_q == S_READ_ACTS) && data_rd_req_i && !pend_q && !rvalid_q;
    assign data_rd_valid_o = rvalid_q;
    assign data_rd_o       = data_rd_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            lane_q    <= '0;
            act_ptr_q <= '0;
            wcnt_q    <= '0;
            rd_ptr_q  <= '0;
            pend_q    <= 1'b0;
            rvalid_q  <= 1'b0;
        end else if (state_q == S_IDLE) begin
            lane_q    <= '0;
            act_ptr_q <= '0;
            wcnt_q    <= '0;
            rd_ptr_q  <= '0;
            pend_q    <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            if (act_wr) begin
                lane_q    <= lane_q + 1'b1;
                act_ptr_q <= act_ptr_q + 1'b1;
            end
            if (wgt_wr_o.en) begin
                wcnt_q <= wcnt_q + 1'b1;
            end
            // Buffer read and then one register stage before the APB sees it
            pend_q   <= rd_issue;
            rvalid_q <= pend_q;
            if (rvalid_q) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == S_LOAD_ACTS) && wr_hs) begin
            word_q <= word_i;
        end
        if (pend_q) begin
            data_rd_q <= buf_rdata_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Convolution window walk
    ////////////////////////////////////////////////////////////

    assign fx_end  = (fx_q == fs - 1'b1);
    assign fy_end  = (fy_q == fs - 1'b1);
    assign ox_end  = (ox_q == out_dim - 1'b1);
    assign oy_end  = (oy_q == out_dim - 1'b1);
    assign walking = (state_q == S_COMPUTE) && !walk_done_q;
    // Write-back owns the port for one cycle
    assign rd_fire = walking && !result_valid_i;
    assign rd_addr = AW'(oy_q + fy_q) * AW'(dim) + AW'(ox_q + fx_q);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            {ox_q, oy_q, fx_q, fy_q} <= '0;
            walk_done_q <= 1'b0;
            out_ptr_q   <= '0;
            tap_ctr_q   <= '0;
            tap_valid_q <= 1'b0;
            tap_idx_q   <= '0;
            tap_first_q <= 1'b0;
            tap_last_q  <= 1'b0;
        end else begin
            tap_valid_q <= rd_fire;
            tap_idx_q   <= tap_ctr_q;
            tap_first_q <= (tap_ctr_q == 4'd0);
            tap_last_q  <= fx_end && fy_end;
            if (state_q != S_COMPUTE) begin
                {ox_q, oy_q, fx_q, fy_q} <= '0;
                walk_done_q <= 1'b0;
                out_ptr_q   <= '0;
                tap_ctr_q   <= '0;
            end else begin
                if (rd_fire) begin
                    tap_ctr_q <= (fx_end && fy_end) ? 4'd0 : tap_ctr_q + 1'b1;
                    // Column, then row, then output x, then output y
                    if (!fx_end) begin
                        fx_q <= fx_q + 1'b1;
                    end else begin
                        fx_q <= '0;
                        if (!fy_end) begin
                            fy_q <= fy_q + 1'b1;
                        end else begin
                            fy_q <= '0;
                            if (!ox_end) begin
                                ox_q <= ox_q + 1'b1;
                            end else begin
                                ox_q <= '0;
                                if (!oy_end) oy_q <= oy_q + 1'b1;
                                else walk_done_q <= 1'b1;
                            end
                        end
                    end
                end
                if (result_valid_i) begin
                    out_ptr_q <= out_ptr_q + 1'b1;
                end
            end
        end
    end

    assign tap_o = '{valid: tap_valid_q, pixel: buf_rdata_i, tap: tap_idx_q,
                     first: tap_first_q, last: tap_last_q};

    ////////////////////////////////////////////////////////////
    // Buffer port arbitration
    ////////////////////////////////////////////////////////////

    always_comb begin
        buf_req_o = '0;
        case (state_q)
            S_LOAD_ACTS: begin
                buf_req_o.en    = act_wr;
                buf_req_o.we    = 1'b1;
                buf_req_o.addr  = 9'(act_ptr_q);
                buf_req_o.wdata = (lane_q == 2'd0) ? word_i.acts[0] : word_q.acts[lane_q];
            end
            S_COMPUTE: begin
                if (result_valid_i) begin
                    // Output map sits right after the input map
                    buf_req_o.en    = 1'b1;
                    buf_req_o.we    = 1'b1;
                    buf_req_o.addr  = 9'(npix + out_ptr_q);
                    buf_req_o.wdata = result_i;
                end else begin
                    buf_req_o.en   = walking;
                    buf_req_o.addr = 9'(rd_addr);
                end
            end
            S_READ_ACTS: begin
                buf_req_o.en   = rd_issue;
                buf_req_o.addr = 9'(npix + rd_ptr_q);
            end
            default: ;
        endcase
    end

    // Write-back never runs past the end of the output map
    assert property (@(posedge clk) disable iff (!nrst)
        (state_q == S_COMPUTE) && result_valid_i |-> out_ptr_q < nout);

endmodule

`default_nettype wire

// File: qracc_act_buffer.sv
// Activation memory with one port shared by loads, the window walk and write-back
// Read data appears one cycle after a read request
`timescale 1ns/100ps
`default_nettype none

module qracc_act_buffer
    import qracc_data_pkg::*;
#(
    parameter int BUF_DEPTH = 512
) (
    input  logic         clk,
    input  logic         nrst,
    input  act_buf_req_t req_i,
    output act_t         rdata_o
);

    act_t mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (req_i.en && req_i.we) begin
            mem[req_i.addr] <= req_i.wdata;
        end
    end

    // Registered read port that holds its value between reads
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rdata_o <= '0;
        end else if (req_i.en && !req_i.we) begin
            rdata_o <= mem[req_i.addr];
        end
    end

    // Input and output maps must both fit behind known controller addresses
    assert property (@(posedge clk) disable iff (!nrst)
        req_i.en |-> !$isunknown(req_i.addr) && req_i.addr < BUF_DEPTH);

endmodule

`default_nettype wire

// File: qracc_csr.sv
// APB register block with the config, trigger, status and data window registers
// DATA accesses hold pready low until the controller answers
`timescale 1ns/100ps
`default_nettype none

module qracc_csr
    import qracc_cfg_pkg::*;
    import qracc_data_pkg::*;
(
    input  logic          clk,
    input  logic          nrst,

    // APB slave
    input  logic          psel_i,
    input  logic          penable_i,
    input  logic          pwrite_i,
    input  logic [3:0]    paddr_i,
    input  logic [31:0]   pwdata_i,
    output logic [31:0]   prdata_o,
    output logic          pready_o,
    output logic          pslverr_o,

    // Towards the controller
    output qracc_config_t cfg_o,
    output qracc_cmd_t    cmd_o,
    input  logic          busy_i,
    output logic          data_wr_valid_o,
    output logic [31:0]   data_wr_o,
    input  logic          data_wr_ready_i,
    output logic          data_rd_req_o,
    input  logic          data_rd_valid_i,
    input  act_t          data_rd_i
);

    logic          access;
    logic          wr_main;
    logic          wr_cfg;
    logic          sel_data;
    qracc_config_t cfg_q;
    qracc_cmd_t    cmd_q;

    ////////////////////////////////////////////////////////////
    // Access decode
    ////////////////////////////////////////////////////////////

    assign access   = psel_i && penable_i;
    assign sel_data = (paddr_i == CSR_ADDR_DATA);
    assign wr_main  = access && pwrite_i && (paddr_i == CSR_ADDR_MAIN);
    assign wr_cfg   = access && pwrite_i && (paddr_i == CSR_ADDR_CONFIG);

    assign data_wr_valid_o = access && pwrite_i && sel_data;
    assign data_wr_o       = pwdata_i;
    assign data_rd_req_o   = access && !pwrite_i && sel_data;

    // Registers answer at once and the data window waits for the controller
    always_comb begin
        pready_o = access;
        if (data_wr_valid_o) begin
            pready_o = data_wr_ready_i;
        end else if (data_rd_req_o) begin
            pready_o = data_rd_valid_i;
        end
    end

    always_comb begin
        case (paddr_i)
            CSR_ADDR_CONFIG: prdata_o = cfg_q;
            CSR_ADDR_STATUS: prdata_o = {31'd0, busy_i};
            CSR_ADDR_DATA:   prdata_o = {24'd0, data_rd_i};
            default:         prdata_o = '0;
        endcase
    end

    assign pslverr_o = 1'b0;

    ////////////////////////////////////////////////////////////
    // Config register and command pulses
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cfg_q <= '0;
            cmd_q <= '0;
        end else begin
            // Trigger and clear last exactly one cycle
            cmd_q <= '0;
            if (wr_cfg) begin
                cfg_q <= pwdata_i;
            end
            if (wr_main) begin
                cmd_q.trigger <= qracc_trigger_t'(pwdata_i[2:0]);
                cmd_q.clear   <= pwdata_i[3];
            end
        end
    end

    assign cfg_o = cfg_q;
    assign cmd_o = cmd_q;

    // No stall answer from the controller may leak outside an access phase
    assert property (@(posedge clk) disable iff (!nrst)
        data_rd_valid_i |-> data_rd_req_o);

endmodule

`default_nettype wire

// File: qracc_data_pkg.sv
// Datapath types for pixels, weights, the shared data word and the inner request structs
// Imported by the controller, the activation buffer, the MAC unit and the top level
`default_nettype none

package qracc_data_pkg;

    typedef logic [7:0]        act_t;
    typedef logic signed [7:0] wgt_t;

    // One bus word seen as four pixels or as four weights with lane 0 in the low byte
    typedef union packed {
        act_t [3:0] acts;
        wgt_t [3:0] wgts;
    } qracc_word_u;

    // Single port request into the activation memory
    typedef struct packed {
        logic       en;
        logic       we;
        logic [8:0] addr;
        act_t       wdata;
    } act_buf_req_t;

    // One filter tap where first clears the sum and last closes the output pixel
    typedef struct packed {
        logic       valid;
        act_t       pixel;
        logic [3:0] tap;
        logic       first;
        logic       last;
    } mac_tap_t;

    // Four weights at once starting at index base
    typedef struct packed {
        logic        en;
        qracc_word_u word;
        logic [3:0]  base;
    } wgt_wr_t;

endpackage

`default_nettype wire

// File: qracc_cfg_pkg.sv
// Control-side definitions for the configuration word, command triggers and register map
// Shared by the APB block, the controller and the testbench
`default_nettype none

package qracc_cfg_pkg;

    // Register word at CONFIG with fmap_dim in the low bits
    typedef struct packed {
        logic [19:0] reserved;
        logic [4:0]  out_shift;
        logic [1:0]  filter_size;
        logic [4:0]  fmap_dim;
    } qracc_config_t;

    typedef enum logic [2:0] {
        TRIG_IDLE         = 3'd0,
        TRIG_LOAD_ACTS    = 3'd1,
        TRIG_LOAD_WEIGHTS = 3'd2,
        TRIG_COMPUTE      = 3'd3,
        TRIG_READ_ACTS    = 3'd4
    } qracc_trigger_t;

    // Byte addresses on the APB side
    localparam logic [3:0] CSR_ADDR_MAIN   = 4'h0;
    localparam logic [3:0] CSR_ADDR_CONFIG = 4'h4;
    localparam logic [3:0] CSR_ADDR_STATUS = 4'h8;
    localparam logic [3:0] CSR_ADDR_DATA   = 4'hC;

    // One-cycle command pulse towards the controller
    typedef struct packed {
        qracc_trigger_t trigger;
        logic           clear;
    } qracc_cmd_t;

endpackage

`default_nettype wire
